/* hw/cc_pkg.sv */
package cc_pkg;

    // board geometry, fixed for every game
    localparam int board_dim = 6;
    localparam int cell_count = board_dim * board_dim;

    typedef enum logic [2:0] {
        red    = 3'd0,
        blue   = 3'd1,
        green  = 3'd2,
        yellow = 3'd3,
        orange = 3'd4,
        purple = 3'd5,
        empty  = 3'd7
    } color_e;

    // row-major, row * 6 + column
    typedef logic [5:0] cell_idx_t;
    typedef logic [2:0] coord_t;

    // element k holds cell k
    typedef color_e [cell_count-1:0] board_t;
    typedef logic [cell_count-1:0] clear_mask_t;

    typedef enum logic [1:0] {
        up    = 2'd0,
        down  = 2'd1,
        left  = 2'd2,
        right = 2'd3
    } action_e;

    typedef struct packed {
        action_e dir;
        coord_t  row;
        coord_t  col;
    } action_t;

    // wraps modulo 128
    typedef logic [6:0] score_t;

    typedef enum logic [2:0] {
        idle,
        load_actions,
        scan,
        clear,
        next_action,
        report
    } state_e;

endpackage

/* hw/line_match.sv */
`timescale 1ns/1ns

module line_match (
    input  cc_pkg::color_e [cc_pkg::board_dim-1:0] cells,
    output logic [cc_pkg::board_dim-3:0]           hits,
    output logic [cc_pkg::board_dim-1:0]           covered
);

    // one window per starting cell, three cells wide
    always_comb begin
        covered = '0;
        for (int w = 0; w < cc_pkg::board_dim - 2; w++) begin
            hits[w] = (cells[w] != cc_pkg::empty)
                   && (cells[w] == cells[w+1])
                   && (cells[w+1] == cells[w+2]);
            if (hits[w]) begin
                covered[w +: 3] = 3'b111;
            end
        end
    end

endmodule

/* hw/board_store.sv */
`timescale 1ns/1ns

module board_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                color_valid,
    input  cc_pkg::color_e      color,
    input  logic                swap_en,
    input  cc_pkg::cell_idx_t   swap_a,
    input  cc_pkg::cell_idx_t   swap_b,
    input  logic                clear_en,
    input  cc_pkg::clear_mask_t clear_mask,
    input  logic                game_end,
    output cc_pkg::board_t      board
);

    cc_pkg::board_t    cells;
    cc_pkg::cell_idx_t load_ptr;
    logic              load_ok;

    // writes past the last cell are dropped
    assign load_ok = color_valid && (load_ptr < cc_pkg::cell_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < cc_pkg::cell_count; k++) begin
                cells[k] <= cc_pkg::red;
            end
            load_ptr <= '0;
        end else if (game_end) begin
            for (int k = 0; k < cc_pkg::cell_count; k++) begin
                cells[k] <= cc_pkg::red;
            end
            load_ptr <= '0;
        end else if (clear_en) begin
            for (int k = 0; k < cc_pkg::cell_count; k++) begin
                if (clear_mask[k]) begin
                    cells[k] <= cc_pkg::empty;
                end
            end
        end else if (swap_en) begin
            // legality already checked by the controller
            cells[swap_a] <= cells[swap_b];
            cells[swap_b] <= cells[swap_a];
        end else if (load_ok) begin
            cells[load_ptr] <= color;
            load_ptr <= load_ptr + 6'd1;
        end
    end

    assign board = cells;

endmodule

/* hw/action_queue.sv */
`timescale 1ns/1ns

module action_queue #(
    parameter int max_actions = 10
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            action_valid,
    input  cc_pkg::action_t action,
    input  logic            pop,
    input  logic            game_end,
    output cc_pkg::action_t head,
    output logic            action_left,
    output logic            started
);

    localparam int ptr_w = $clog2(max_actions + 1);

    cc_pkg::action_t  entries [max_actions];
    logic [ptr_w-1:0] fill_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             sealed;
    logic             append;

    // closed once the action burst ends, until the game is over
    assign append = action_valid && !sealed && (fill_ptr < max_actions);

    always_ff @(posedge clk) begin
        if (append) begin
            entries[fill_ptr] <= action;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_ptr <= '0;
            rd_ptr   <= '0;
            started  <= 1'b0;
            sealed   <= 1'b0;
        end else if (game_end) begin
            fill_ptr <= '0;
            rd_ptr   <= '0;
            started  <= 1'b0;
            sealed   <= 1'b0;
        end else begin
            if (append) begin
                fill_ptr <= fill_ptr + 1'b1;
                started  <= 1'b1;
            end
            if (started && !action_valid) begin
                sealed <= 1'b1;
            end
            if (pop && action_left) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign action_left = rd_ptr < fill_ptr;
    assign head = action_left ? entries[rd_ptr] : '0;

endmodule

/* hw/match_scan.sv */
`timescale 1ns/1ns

module match_scan (
    input  logic                clk,
    input  logic                rst_n,
    input  cc_pkg::board_t      board,
    input  logic                scan_start,
    input  logic                game_end,
    output logic                scan_done,
    output cc_pkg::clear_mask_t clear_mask,
    output cc_pkg::score_t      total
);

    localparam int dim = cc_pkg::board_dim;

    cc_pkg::color_e [dim-1:0] row_cells;
    cc_pkg::color_e [dim-1:0] col_cells;
    logic [dim-3:0]           row_hits;
    logic [dim-3:0]           col_hits;
    logic [dim-1:0]           row_cov;
    logic [dim-1:0]           col_cov;
    cc_pkg::clear_mask_t      line_mask;
    cc_pkg::coord_t           line;
    logic                     busy;

    // row k and column k share one cycle
    always_comb begin
        line_mask = '0;
        for (int j = 0; j < dim; j++) begin
            row_cells[j] = board[int'(line) * dim + j];
            col_cells[j] = board[j * dim + int'(line)];
            if (row_cov[j]) begin
                line_mask[int'(line) * dim + j] = 1'b1;
            end
            if (col_cov[j]) begin
                line_mask[j * dim + int'(line)] = 1'b1;
            end
        end
    end

    line_match row_match_inst (
        .cells   (row_cells),
        .hits    (row_hits),
        .covered (row_cov)
    );

    line_match col_match_inst (
        .cells   (col_cells),
        .hits    (col_hits),
        .covered (col_cov)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            line       <= '0;
            clear_mask <= '0;
            total      <= '0;
        end else if (game_end) begin
            busy       <= 1'b0;
            line       <= '0;
            clear_mask <= '0;
            total      <= '0;
        end else if (scan_start) begin
            busy       <= 1'b1;
            line       <= '0;
            clear_mask <= '0;
        end else if (busy) begin
            clear_mask <= clear_mask | line_mask;
            total <= total + cc_pkg::score_t'($countones(row_hits) + $countones(col_hits));
            if (scan_done) begin
                busy <= 1'b0;
                line <= '0;
            end else begin
                line <= line + 3'd1;
            end
        end
    end

    // last line pair is on the board this cycle
    assign scan_done = busy && (line == cc_pkg::coord_t'(dim - 1));

endmodule

/* hw/cc_ctrl.sv */
`timescale 1ns/1ns

module cc_ctrl #(
    parameter int max_actions = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cc_pkg::board_t    board,
    input  logic              started,
    input  logic              action_left,
    input  cc_pkg::action_t   head,
    input  logic              scan_done,
    input  cc_pkg::score_t    total,
    input  logic              action_valid,
    output logic              scan_start,
    output logic              clear_en,
    output logic              swap_en,
    output cc_pkg::cell_idx_t swap_a,
    output cc_pkg::cell_idx_t swap_b,
    output logic              pop,
    output logic              game_end,
    output logic              out_valid,
    output cc_pkg::score_t    score
);

    localparam int cnt_w = $clog2(max_actions + 1);

    cc_pkg::state_e state;
    cc_pkg::state_e state_nxt;
    logic [cnt_w-1:0] act_cnt;
    cc_pkg::coord_t   nb_row;
    cc_pkg::coord_t   nb_col;
    logic             src_ok;
    logic             nb_ok;
    logic             legal;

    function automatic cc_pkg::cell_idx_t cell_of(cc_pkg::coord_t r, cc_pkg::coord_t c);
        return cc_pkg::cell_idx_t'(r) * 6'd6 + cc_pkg::cell_idx_t'(c);
    endfunction

    // neighbor in the head action's direction
    always_comb begin
        nb_row = head.row;
        nb_col = head.col;
        nb_ok  = 1'b0;
        case (head.dir)
            cc_pkg::up: begin
                nb_row = head.row - 3'd1;
                nb_ok  = head.row != 3'd0;
            end
            cc_pkg::down: begin
                nb_row = head.row + 3'd1;
                nb_ok  = head.row < cc_pkg::board_dim - 1;
            end
            cc_pkg::left: begin
                nb_col = head.col - 3'd1;
                nb_ok  = head.col != 3'd0;
            end
            cc_pkg::right: begin
                nb_col = head.col + 3'd1;
                nb_ok  = head.col < cc_pkg::board_dim - 1;
            end
        endcase
    end

    assign swap_a = cell_of(head.row, head.col);
    assign swap_b = cell_of(nb_row, nb_col);
    assign src_ok = (head.row < cc_pkg::board_dim) && (head.col < cc_pkg::board_dim);
    // both cells must hold a candy
    assign legal  = src_ok && nb_ok
                 && (board[swap_a] != cc_pkg::empty)
                 && (board[swap_b] != cc_pkg::empty);

    always_comb begin
        state_nxt  = state;
        scan_start = 1'b0;
        clear_en   = 1'b0;
        swap_en    = 1'b0;
        pop        = 1'b0;
        game_end   = 1'b0;
        case (state)
            cc_pkg::idle: begin
                if (action_valid) begin
                    state_nxt = cc_pkg::load_actions;
                end
            end
            cc_pkg::load_actions: begin
                if (started && !action_valid) begin
                    scan_start = 1'b1;
                    state_nxt  = cc_pkg::scan;
                end
            end
            cc_pkg::scan: begin
                if (scan_done) begin
                    state_nxt = cc_pkg::clear;
                end
            end
            cc_pkg::clear: begin
                clear_en  = 1'b1;
                state_nxt = cc_pkg::next_action;
            end
            cc_pkg::next_action: begin
                if (action_left && (act_cnt < max_actions)) begin
                    pop = 1'b1;
                    // illegal action just falls through to the next one
                    if (legal) begin
                        swap_en    = 1'b1;
                        scan_start = 1'b1;
                        state_nxt  = cc_pkg::scan;
                    end
                end else begin
                    state_nxt = cc_pkg::report;
                end
            end
            cc_pkg::report: begin
                game_end  = 1'b1;
                state_nxt = cc_pkg::idle;
            end
            default: begin
                state_nxt = cc_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= cc_pkg::idle;
            act_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (game_end) begin
                act_cnt <= '0;
            end else if (pop) begin
                act_cnt <= act_cnt + 1'b1;
            end
        end
    end

    // score only shows while out_valid is up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            score     <= '0;
        end else begin
            out_valid <= state == cc_pkg::report;
            score     <= (state == cc_pkg::report) ? total : '0;
        end
    end

endmodule

/* hw/cc_top.sv */
`timescale 1ns/1ns

module cc_top #(
    parameter int max_actions = 10
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            color_valid,
    input  cc_pkg::color_e  color,
    input  logic            action_valid,
    input  cc_pkg::action_t action,
    output logic            out_valid,
    output cc_pkg::score_t  score
);

    cc_pkg::board_t      board;
    cc_pkg::clear_mask_t clear_mask;
    cc_pkg::score_t      total;
    cc_pkg::action_t     head;
    cc_pkg::cell_idx_t   swap_a;
    cc_pkg::cell_idx_t   swap_b;
    logic                scan_done;
    logic                action_left;
    logic                started;
    logic                scan_start;
    logic                clear_en;
    logic                swap_en;
    logic                pop;
    logic                game_end;

    board_store board_store_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .color_valid (color_valid),
        .color       (color),
        .swap_en     (swap_en),
        .swap_a      (swap_a),
        .swap_b      (swap_b),
        .clear_en    (clear_en),
        .clear_mask  (clear_mask),
        .game_end    (game_end),
        .board       (board)
    );

    action_queue #(
        .max_actions (max_actions)
    ) action_queue_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .action_valid (action_valid),
        .action       (action),
        .pop          (pop),
        .game_end     (game_end),
        .head         (head),
        .action_left  (action_left),
        .started      (started)
    );

    match_scan match_scan_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .board      (board),
        .scan_start (scan_start),
        .game_end   (game_end),
        .scan_done  (scan_done),
        .clear_mask (clear_mask),
        .total      (total)
    );

    cc_ctrl #(
        .max_actions (max_actions)
    ) cc_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .board        (board),
        .started      (started),
        .action_left  (action_left),
        .head         (head),
        .scan_done    (scan_done),
        .total        (total),
        .action_valid (action_valid),
        .scan_start   (scan_start),
        .clear_en     (clear_en),
        .swap_en      (swap_en),
        .swap_a       (swap_a),
        .swap_b       (swap_b),
        .pop          (pop),
        .game_end     (game_end),
        .out_valid    (out_valid),
        .score        (score)
    );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // release on a falling edge, away from the flops
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* sim/cc_properties.sv */
`timescale 1ns/1ns

module cc_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           out_valid,
    input cc_pkg::score_t score
);

    // set by the first result after reset
    logic seen_valid;
    int   fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_valid <= 1'b0;
        end else if (out_valid) begin
            seen_valid <= 1'b1;
        end
    end

    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high on two consecutive cycles");
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high while reset is asserted");
    end

    zero_before_result: assert property (@(posedge clk) disable iff (!rst_n)
        (!seen_valid && !out_valid) |-> (score == '0))
    else begin
        fail_count++;
        $error("score not zero before the first result");
    end

endmodule

bind cc_top cc_properties cc_properties_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .score     (score)
);

/* sim/tb_cc.sv */
`timescale 1ns/1ns

module tb_cc;

    localparam int max_actions = 10;
    localparam int dim         = cc_pkg::board_dim;
    localparam int wait_limit  = 400;

    logic            clk;
    logic            rst_n;
    logic            color_valid;
    cc_pkg::color_e  color;
    logic            action_valid;
    cc_pkg::action_t action;
    logic            out_valid;
    cc_pkg::score_t  score;

    cc_pkg::board_t  init_board;
    cc_pkg::board_t  model_board;
    cc_pkg::action_t act_buf [$];
    logic [31:0]     rng_state;

    tb_clk_gen #(
        .period_ns    (20),
        .reset_cycles (2)
    ) clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cc_top #(
        .max_actions (max_actions)
    ) cc_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .color_valid  (color_valid),
        .color        (color),
        .action_valid (action_valid),
        .action       (action),
        .out_valid    (out_valid),
        .score        (score)
    );

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic cc_pkg::color_e to_color(int v);
        logic [2:0] bits;
        bits = v[2:0];
        return cc_pkg::color_e'(bits);
    endfunction

    function automatic cc_pkg::action_t make_action(cc_pkg::action_e dir, int r, int c);
        cc_pkg::action_t a;
        a.dir = dir;
        a.row = r[2:0];
        a.col = c[2:0];
        return a;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_score(input string name, input cc_pkg::score_t got,
                               input cc_pkg::score_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic same_candy(int a, int b, int c);
        return (model_board[a] != cc_pkg::empty)
            && (model_board[a] == model_board[b])
            && (model_board[b] == model_board[c]);
    endfunction

    // every window scores on its own, a run of four counts twice
    task automatic scan_and_clear(inout cc_pkg::score_t acc);
        cc_pkg::clear_mask_t mask;
        mask = '0;
        for (int line = 0; line < dim; line++) begin
            for (int w = 0; w < dim - 2; w++) begin
                if (same_candy(line * dim + w, line * dim + w + 1, line * dim + w + 2)) begin
                    acc = acc + 1'b1;
                    mask[line * dim + w +: 3] = 3'b111;
                end
                if (same_candy(w * dim + line, (w + 1) * dim + line, (w + 2) * dim + line)) begin
                    acc = acc + 1'b1;
                    mask[w * dim + line] = 1'b1;
                    mask[(w + 1) * dim + line] = 1'b1;
                    mask[(w + 2) * dim + line] = 1'b1;
                end
            end
        end
        for (int k = 0; k < cc_pkg::cell_count; k++) begin
            if (mask[k]) begin
                model_board[k] = cc_pkg::empty;
            end
        end
    endtask

    task automatic apply_action(input cc_pkg::action_t act, inout cc_pkg::score_t acc);
        int r;
        int c;
        int nr;
        int nc;
        cc_pkg::color_e tmp;
        r = int'(act.row);
        c = int'(act.col);
        nr = r;
        nc = c;
        case (act.dir)
            cc_pkg::up:    nr = r - 1;
            cc_pkg::down:  nr = r + 1;
            cc_pkg::left:  nc = c - 1;
            default:       nc = c + 1;
        endcase
        if (r < dim && c < dim && nr >= 0 && nr < dim && nc >= 0 && nc < dim) begin
            if (model_board[r * dim + c] != cc_pkg::empty
                    && model_board[nr * dim + nc] != cc_pkg::empty) begin
                tmp = model_board[r * dim + c];
                model_board[r * dim + c] = model_board[nr * dim + nc];
                model_board[nr * dim + nc] = tmp;
                scan_and_clear(acc);
            end
        end
    endtask

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                stop_with_failure("reset was never released");
            end
        end
    endtask

    // hand_score below zero means the model alone decides
    task automatic play_game(input string label, input int load_count, input int hand_score);
        cc_pkg::score_t expected;
        int waited;
        // cells that are not loaded keep the reset color
        for (int k = load_count; k < cc_pkg::cell_count; k++) begin
            init_board[k] = cc_pkg::red;
        end
        model_board = init_board;
        expected = '0;
        scan_and_clear(expected);
        for (int i = 0; i < act_buf.size() && i < max_actions; i++) begin
            apply_action(act_buf[i], expected);
        end
        if (hand_score >= 0 && int'(expected) != hand_score) begin
            stop_with_failure($sformatf("model and hand count disagree in %s", label));
        end
        for (int k = 0; k < load_count; k++) begin
            color_valid = 1'b1;
            color = init_board[k];
            @(negedge clk);
        end
        color_valid = 1'b0;
        foreach (act_buf[i]) begin
            action_valid = 1'b1;
            action = act_buf[i];
            @(negedge clk);
        end
        action_valid = 1'b0;
        waited = 0;
        while (out_valid !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                stop_with_failure($sformatf("out_valid never came in %s", label));
            end
        end
        check_score($sformatf("score in %s", label), score, expected);
        @(negedge clk);
        check_flag($sformatf("out_valid after %s", label), out_valid, 1'b0);
    endtask

    // neighbors differ along rows and columns, so no triples
    task automatic fill_pattern(input int offset);
        for (int r = 0; r < dim; r++) begin
            for (int c = 0; c < dim; c++) begin
                init_board[r * dim + c] = to_color((r + 2 * c) % 5 + offset);
            end
        end
    endtask

    task automatic quiet_board();
        fill_pattern(0);
        act_buf.delete();
        act_buf.push_back(make_action(cc_pkg::up, 0, 0));
        play_game("quiet board", cc_pkg::cell_count, 0);
    endtask

    task automatic initial_runs();
        fill_pattern(0);
        for (int c = 0; c < 3; c++) begin
            init_board[c] = cc_pkg::purple;
        end
        for (int r = 2; r < dim; r++) begin
            init_board[r * dim + 5] = cc_pkg::purple;
        end
        act_buf.delete();
        act_buf.push_back(make_action(cc_pkg::down, 5, 5));
        play_game("initial runs", cc_pkg::cell_count, 3);
    endtask

    task automatic swap_then_skip();
        fill_pattern(0);
        init_board[3 * dim + 0] = cc_pkg::purple;
        init_board[3 * dim + 1] = cc_pkg::purple;
        init_board[4 * dim + 2] = cc_pkg::purple;
        act_buf.delete();
        act_buf.push_back(make_action(cc_pkg::up, 4, 2));
        // (3,0) was emptied by the first swap
        act_buf.push_back(make_action(cc_pkg::down, 2, 0));
        play_game("swap then skip", cc_pkg::cell_count, 1);
    endtask

    task automatic random_games();
        logic [31:0] rnd;
        int colors;
        int n_act;
        for (int g = 0; g < 7; g++) begin
            // fewer colors give long runs and many scoring swaps
            colors = (g < 3) ? 6 : ((g < 6) ? 2 : 3);
            n_act = (g == 6) ? max_actions + 2 : max_actions;
            for (int k = 0; k < cc_pkg::cell_count; k++) begin
                rnd = next_random();
                init_board[k] = to_color(int'(rnd % 32'(colors)));
            end
            act_buf.delete();
            for (int i = 0; i < n_act; i++) begin
                rnd = next_random();
                act_buf.push_back(make_action(cc_pkg::action_e'(rnd[1:0]),
                                              int'(rnd[10:8]) % dim,
                                              int'(rnd[18:16]) % dim));
            end
            play_game($sformatf("random game %0d", g), cc_pkg::cell_count, -1);
        end
    endtask

    task automatic back_to_back();
        for (int k = 0; k < cc_pkg::cell_count; k++) begin
            init_board[k] = cc_pkg::blue;
        end
        act_buf.delete();
        act_buf.push_back(make_action(cc_pkg::right, 0, 0));
        play_game("all blue", cc_pkg::cell_count, 48);
        // rows 3 to 5 must come back red, not empty
        fill_pattern(1);
        act_buf.delete();
        act_buf.push_back(make_action(cc_pkg::left, 0, 0));
        play_game("half loaded", 18, 18);
    endtask

    initial begin
        color_valid  = 1'b0;
        color        = cc_pkg::red;
        action_valid = 1'b0;
        action       = '0;
        rng_state    = 32'd46;
        wait_for_reset();
        check_flag("out_valid", out_valid, 1'b0);
        check_score("score", score, '0);
        quiet_board();
        initial_runs();
        swap_then_skip();
        random_games();
        back_to_back();
        @(negedge clk);
        if (cc_top_inst.cc_properties_inst.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "port assertions failed during the run");
        end
    end

endmodule

/* verilog.f */
hw/cc_pkg.sv
hw/line_match.sv
hw/board_store.sv
hw/action_queue.sv
hw/match_scan.sv
hw/cc_ctrl.sv
hw/cc_top.sv
sim/tb_clk_gen.sv
sim/cc_properties.sv
sim/tb_cc.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cc -f verilog.f -o sim_cc

./obj_dir/sim_cc > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
